// File: common/ipi_soc_cfg.svh
`ifndef IPI_SOC_CFG_SVH
`define IPI_SOC_CFG_SVH

// Number of cores, one IPI unit each
`define IPI_NUM_CORES 2

// Main RAM word-address width
`define RAM_ADR_BITS 8

// Main RAM region: top 7 address bits all zero
`define RAM_REGION_WIDTH 7
`define RAM_REGION_MATCH 7'h00

// IPI region
`define IPI_REGION_WIDTH 16
`define IPI_REGION_MATCH 16'h9800

`define IPI_IRQ_BIT 0  // IPI position in each core's irq vector

`endif

// File: common/ipi_soc_pkg.sv
package ipi_soc_pkg;

   // Wishbone bus fields
   typedef logic [31:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;

   // IPI message fields
   typedef logic [15:0] ipi_payload_t;
   typedef logic [3:0]  ipi_sender_t;  // Id of the sending core

   // One core's interrupt vector
   typedef logic [31:0] irq_vec_t;

   // Mailbox state of one core
   typedef enum logic {
      IPI_IDLE    = 1'b0,
      IPI_PENDING = 1'b1
   } ipi_state_t;

endpackage

// File: design/multicore_ipi_top.sv
`timescale 1ns/1ps
`include "ipi_soc_cfg.svh"

module multicore_ipi_top (
   input  logic                                        wb_clk_i,
   input  logic                                        rst_n_i,
   input  ipi_soc_pkg::wb_adr_t                        wb_adr_i,
   input  ipi_soc_pkg::wb_dat_t                        wb_dat_i,
   input  ipi_soc_pkg::wb_sel_t                        wb_sel_i,
   input  logic                                        wb_we_i,
   input  logic                                        wb_cyc_i,
   input  logic                                        wb_stb_i,
   output ipi_soc_pkg::wb_dat_t                        wb_dat_o,
   output logic                                        wb_ack_o,
   output logic                                        wb_err_o,
   output ipi_soc_pkg::irq_vec_t [`IPI_NUM_CORES-1:0]  irq_o
);

   import ipi_soc_pkg::*;

   logic                        ram_we;
   logic [`RAM_ADR_BITS-1:0]    ram_adr;
   wb_sel_t                     ram_sel;
   wb_dat_t                     wr_dat;
   wb_dat_t                     ram_dat;
   logic [`IPI_NUM_CORES-1:0]   send_we;
   logic [`IPI_NUM_CORES-1:0]   ack_we;
   logic                        rd_ipi;
   logic [2:0]                  rd_core;
   logic                        rd_reg;
   logic                        acc;
   wb_dat_t [`IPI_NUM_CORES-1:0] core_status;
   logic [`IPI_NUM_CORES-1:0]   core_pending;

   ////////////////////////////////////////
   // Bus decode
   ////////////////////////////////////////
   wb_slave_decode u_decode (
      .wb_clk_i  (wb_clk_i),
      .rst_n_i   (rst_n_i),
      .wb_adr_i  (wb_adr_i),
      .wb_dat_i  (wb_dat_i),
      .wb_sel_i  (wb_sel_i),
      .wb_we_i   (wb_we_i),
      .wb_cyc_i  (wb_cyc_i),
      .wb_stb_i  (wb_stb_i),
      .wb_ack_o  (wb_ack_o),
      .wb_err_o  (wb_err_o),
      .ram_we_o  (ram_we),
      .ram_adr_o (ram_adr),
      .ram_sel_o (ram_sel),
      .wr_dat_o  (wr_dat),
      .send_we_o (send_we),
      .ack_we_o  (ack_we),
      .rd_ipi_o  (rd_ipi),
      .rd_core_o (rd_core),
      .rd_reg_o  (rd_reg),
      .acc_o     (acc)
   );

   wb_ram u_ram (
      .wb_clk_i  (wb_clk_i),
      .ram_we_i  (ram_we),
      .ram_adr_i (ram_adr),
      .ram_sel_i (ram_sel),
      .wr_dat_i  (wr_dat),
      .rd_dat_o  (ram_dat)
   );

   ////////////////////////////////////////
   // One IPI mailbox per core
   ////////////////////////////////////////
   for (genvar c = 0; c < `IPI_NUM_CORES; c++) begin : g_ipi
      ipi_core u_ipi_core (
         .wb_clk_i  (wb_clk_i),
         .rst_n_i   (rst_n_i),
         .send_we_i (send_we[c]),
         .ack_we_i  (ack_we[c]),
         .wr_dat_i  (wr_dat),
         .status_o  (core_status[c]),
         .pending_o (core_pending[c])
      );
   end

   ipi_collect u_collect (
      .wb_clk_i  (wb_clk_i),
      .rst_n_i   (rst_n_i),
      .acc_i     (acc),
      .rd_ipi_i  (rd_ipi),
      .rd_core_i (rd_core),
      .rd_reg_i  (rd_reg),
      .ram_dat_i (ram_dat),
      .status_i  (core_status),
      .pending_i (core_pending),
      .wb_dat_o  (wb_dat_o),
      .irq_o     (irq_o)
   );

endmodule

// File: design/wb_ram.sv
`timescale 1ns/1ps
`include "ipi_soc_cfg.svh"

module wb_ram (
   input  logic                     wb_clk_i,
   input  logic                     ram_we_i,
   input  logic [`RAM_ADR_BITS-1:0] ram_adr_i,
   input  ipi_soc_pkg::wb_sel_t     ram_sel_i,
   input  ipi_soc_pkg::wb_dat_t     wr_dat_i,
   output ipi_soc_pkg::wb_dat_t     rd_dat_o
);

   import ipi_soc_pkg::*;

   localparam int RAM_WORDS = 2 ** `RAM_ADR_BITS;

   wb_dat_t mem [0:RAM_WORDS-1];

   ////////////////////////////////////////
   // Byte-lane writes
   ////////////////////////////////////////
   always_ff @(posedge wb_clk_i) begin
      if (ram_we_i) begin
         for (int b = 0; b < 4; b++) begin
            if (ram_sel_i[b]) begin
               mem[ram_adr_i][b*8 +: 8] <= wr_dat_i[b*8 +: 8];
            end
         end
      end
   end

   // Asynchronous read, sampled by the collector
   assign rd_dat_o = mem[ram_adr_i];

endmodule

// File: design/wb_slave_decode.sv
`timescale 1ns/1ps
`include "ipi_soc_cfg.svh"

module wb_slave_decode (
   input  logic                      wb_clk_i,
   input  logic                      rst_n_i,
   input  ipi_soc_pkg::wb_adr_t      wb_adr_i,
   input  ipi_soc_pkg::wb_dat_t      wb_dat_i,
   input  ipi_soc_pkg::wb_sel_t      wb_sel_i,
   input  logic                      wb_we_i,
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   output logic                      wb_ack_o,
   output logic                      wb_err_o,
   output logic                      ram_we_o,
   output logic [`RAM_ADR_BITS-1:0]  ram_adr_o,
   output ipi_soc_pkg::wb_sel_t      ram_sel_o,
   output ipi_soc_pkg::wb_dat_t      wr_dat_o,
   output logic [`IPI_NUM_CORES-1:0] send_we_o,
   output logic [`IPI_NUM_CORES-1:0] ack_we_o,
   output logic                      rd_ipi_o,
   output logic [2:0]                rd_core_o,
   output logic                      rd_reg_o,
   output logic                      acc_o
);

   logic       accept;
   logic       hit_ram;
   logic       hit_ipi;
   logic       core_ok;
   logic       good;
   logic       ipi_wr;
   logic [2:0] core_idx;
   logic       ipi_reg;

   ////////////////////////////////////////
   // Region and register decode
   ////////////////////////////////////////
   assign accept   = wb_cyc_i & wb_stb_i & ~(wb_ack_o | wb_err_o); // New request only
   assign hit_ram  = wb_adr_i[31 -: `RAM_REGION_WIDTH] == `RAM_REGION_MATCH;
   assign hit_ipi  = wb_adr_i[31 -: `IPI_REGION_WIDTH] == `IPI_REGION_MATCH;
   assign core_idx = wb_adr_i[5:3];
   assign ipi_reg  = wb_adr_i[2];   // 0 SEND/STATUS, 1 ACK
   assign core_ok  = int'(core_idx) < `IPI_NUM_CORES;
   assign good     = hit_ram | (hit_ipi & core_ok);

   // One-cycle response per accepted request
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
      end else begin
         wb_ack_o <= accept & good;
         wb_err_o <= accept & ~good;
      end
   end

   ////////////////////////////////////////
   // Write strobes, valid at the accept edge
   ////////////////////////////////////////
   assign ram_we_o  = accept & hit_ram & wb_we_i;
   assign ram_adr_o = wb_adr_i[`RAM_ADR_BITS+1:2];  // Upper bits alias
   assign ram_sel_o = wb_sel_i;
   assign wr_dat_o  = wb_dat_i;
   assign ipi_wr    = accept & hit_ipi & core_ok & wb_we_i;

   always_comb begin
      for (int c = 0; c < `IPI_NUM_CORES; c++) begin
         send_we_o[c] = ipi_wr & ~ipi_reg & (int'(core_idx) == c);
         ack_we_o[c]  = ipi_wr & ipi_reg & (int'(core_idx) == c);
      end
   end

   // Read selection for the data collector
   assign rd_ipi_o  = hit_ipi;
   assign rd_core_o = core_idx;
   assign rd_reg_o  = ipi_reg;
   assign acc_o     = accept & good & ~wb_we_i;  // Reads that get an ack

   a_one_resp: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !(wb_ack_o && wb_err_o));
   a_single_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o));

endmodule

// File: ipi/ipi_collect.sv
`timescale 1ns/1ps
`include "ipi_soc_cfg.svh"

module ipi_collect (
   input  logic                                        wb_clk_i,
   input  logic                                        rst_n_i,
   input  logic                                        acc_i,
   input  logic                                        rd_ipi_i,
   input  logic [2:0]                                  rd_core_i,
   input  logic                                        rd_reg_i,
   input  ipi_soc_pkg::wb_dat_t                        ram_dat_i,
   input  ipi_soc_pkg::wb_dat_t [`IPI_NUM_CORES-1:0]   status_i,
   input  logic [`IPI_NUM_CORES-1:0]                   pending_i,
   output ipi_soc_pkg::wb_dat_t                        wb_dat_o,
   output ipi_soc_pkg::irq_vec_t [`IPI_NUM_CORES-1:0]  irq_o
);

   import ipi_soc_pkg::*;

   wb_dat_t ipi_dat;
   wb_dat_t rd_dat;

   // STATUS of the addressed core, ACK reads as zero
   always_comb begin
      ipi_dat = '0;
      for (int c = 0; c < `IPI_NUM_CORES; c++) begin
         if (!rd_reg_i && int'(rd_core_i) == c) begin
            ipi_dat = status_i[c];
         end
      end
   end

   assign rd_dat = rd_ipi_i ? ipi_dat : ram_dat_i;

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         wb_dat_o <= '0;
      end else begin
         wb_dat_o <= acc_i ? rd_dat : '0;   // Zero on writes and errors
      end
   end

   ////////////////////////////////////////
   // Per-core interrupt vectors
   ////////////////////////////////////////
   always_comb begin
      irq_o = '0;
      for (int c = 0; c < `IPI_NUM_CORES; c++) begin
         irq_o[c][`IPI_IRQ_BIT] = pending_i[c];
      end
   end

endmodule

// File: ipi/ipi_core.sv
`timescale 1ns/1ps

module ipi_core (
   input  logic                 wb_clk_i,
   input  logic                 rst_n_i,
   input  logic                 send_we_i,
   input  logic                 ack_we_i,
   input  ipi_soc_pkg::wb_dat_t wr_dat_i,
   output ipi_soc_pkg::wb_dat_t status_o,
   output logic                 pending_o
);

   import ipi_soc_pkg::*;

   ipi_state_t   state;
   ipi_payload_t payload;
   ipi_sender_t  sender;

   ////////////////////////////////////////
   // Mailbox FSM
   ////////////////////////////////////////
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         state   <= IPI_IDLE;
         payload <= '0;
         sender  <= '0;
      end else begin
         case (state)
            IPI_IDLE: begin
               if (send_we_i) begin
                  state   <= IPI_PENDING;
                  payload <= wr_dat_i[15:0];
                  sender  <= wr_dat_i[19:16];
               end
            end
            IPI_PENDING: begin
               // Further sends dropped until the target acks
               if (ack_we_i) begin
                  state <= IPI_IDLE;
               end
            end
            default: state <= IPI_IDLE;
         endcase
      end
   end

   assign pending_o = (state == IPI_PENDING);
   assign status_o  = {pending_o, 11'b0, sender, payload};  // Pending flag on bit 31

   a_state_needs_strobe: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      (!send_we_i && !ack_we_i) |=> $stable(state));

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir -o tb_top_sim
./obj_dir/tb_top_sim 2>&1 | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
   exit 1
fi
exit 0

// File: tb.f
+incdir+common
common/ipi_soc_pkg.sv
design/wb_slave_decode.sv
design/wb_ram.sv
ipi/ipi_core.sv
ipi/ipi_collect.sv
design/multicore_ipi_top.sv
verif/tb_top.sv

// File: verif/tb_top.sv
`timescale 1ns/1ps
`include "ipi_soc_cfg.svh"

module tb_top;

   import ipi_soc_pkg::*;

   localparam int RAND_OPS  = 200;
   localparam int RAM_WORDS = 1 << `RAM_ADR_BITS;

   logic                             wb_clk;
   logic                             rst_n;
   wb_adr_t                          wb_adr;
   wb_dat_t                          wb_dat_w;
   wb_sel_t                          wb_sel;
   logic                             wb_we;
   logic                             wb_cyc;
   logic                             wb_stb;
   wb_dat_t                          wb_dat_r;
   logic                             wb_ack;
   logic                             wb_err;
   irq_vec_t [`IPI_NUM_CORES-1:0]    irq;

   // Stimulus table, one access per entry
   string       t_name[$];
   logic        t_we[$];
   wb_adr_t     t_adr[$];
   wb_dat_t     t_dat[$];
   wb_sel_t     t_sel[$];
   wb_dat_t     t_exp[$];
   logic        t_err[$];
   logic [63:0] t_irq[$];

   wb_dat_t     ref_mem [RAM_WORDS];  // RAM reference model
   logic        ref_valid [RAM_WORDS];
   logic [31:0] lcg_state = 32'd11581;

   multicore_ipi_top u_dut (
      .wb_clk_i (wb_clk),
      .rst_n_i  (rst_n),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w),
      .wb_sel_i (wb_sel),
      .wb_we_i  (wb_we),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_dat_o (wb_dat_r),
      .wb_ack_o (wb_ack),
      .wb_err_o (wb_err),
      .irq_o    (irq)
   );

   initial wb_clk = 1'b0;
   always #4 wb_clk = ~wb_clk;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Expected irq_o for both cores
   function automatic logic [63:0] irq_bits(input logic core1, input logic core0);
      irq_vec_t v1;
      irq_vec_t v0;
      v1 = '0;
      v0 = '0;
      v1[`IPI_IRQ_BIT] = core1;
      v0[`IPI_IRQ_BIT] = core0;
      return {v1, v0};
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("ERR %s expected %h actual %h", name, expected, actual);
         $display("Testbench failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic add_entry(input string name, input logic we, input wb_adr_t adr,
                            input wb_dat_t dat, input wb_sel_t sel, input wb_dat_t exp_dat,
                            input logic exp_err, input logic [63:0] exp_irq);
      t_name.push_back(name);
      t_we.push_back(we);
      t_adr.push_back(adr);
      t_dat.push_back(dat);
      t_sel.push_back(sel);
      t_exp.push_back(exp_dat);
      t_err.push_back(exp_err);
      t_irq.push_back(exp_irq);
   endtask

   // One classic cycle, response due one clock after the request
   task automatic bus_access(input string name, input logic we, input wb_adr_t adr,
                             input wb_dat_t dat, input wb_sel_t sel,
                             output wb_dat_t rd_dat, output logic err);
      @(negedge wb_clk);
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_sel   = sel;
      wb_we    = we;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      @(posedge wb_clk);
      @(negedge wb_clk);
      check_value({name, " single response"}, 64'd1, 64'(wb_ack ^ wb_err));
      rd_dat = wb_dat_r;
      err    = wb_err;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   ////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////
   initial begin : watchdog
      int limit_ns;
      #1;
      limit_ns = (t_name.size() + 2 * RAND_OPS) * 10 * 8 + 1000;
      #(limit_ns);
      $display("Watchdog expired before the tests finished");
      $display("Testbench failed");
      $fatal(1, "timeout");
   end

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin : main
      wb_dat_t                               rd;
      logic                                  err;
      logic [31:0]                           rnd;
      logic [`RAM_ADR_BITS-1:0]              idx;
      logic [`RAM_ADR_BITS-1:0]              idx_rd;
      logic [31-`RAM_REGION_WIDTH-`RAM_ADR_BITS-2:0] alias_bits;
      wb_sel_t                               sel;
      wb_dat_t                               dat;
      wb_adr_t                               adr;

      rst_n    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '0;
      wb_we    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      for (int i = 0; i < RAM_WORDS; i++) begin
         ref_valid[i] = 1'b0;
      end

      // Byte lanes and aliasing
      add_entry("ram full wr",   1, 32'h0000_0010, 32'h1122_3344, 4'hF, 0, 0, irq_bits(0, 0));
      add_entry("ram lane wr",   1, 32'h0000_0010, 32'hAABB_CCDD, 4'h5, 0, 0, irq_bits(0, 0));
      add_entry("ram lane rd",   0, 32'h0000_0010, 0, 4'hF, 32'h11BB_33DD, 0, irq_bits(0, 0));
      add_entry("ram alias rd",  0, 32'h0000_0410, 0, 4'hF, 32'h11BB_33DD, 0, irq_bits(0, 0));
      add_entry("ram alias rd2", 0, 32'h01FF_FC10, 0, 4'hF, 32'h11BB_33DD, 0, irq_bits(0, 0));
      add_entry("ram alias wr",  1, 32'h0040_0010, 32'h0000_EE00, 4'h2, 0, 0, irq_bits(0, 0));
      add_entry("ram merge rd",  0, 32'h0000_0010, 0, 4'hF, 32'h11BB_EEDD, 0, irq_bits(0, 0));
      // Error responses, writes land on the word that is read back below
      add_entry("unmapped rd",   0, 32'h9000_0000, 0, 4'hF, 0, 1, irq_bits(0, 0));
      add_entry("unmapped wr",   1, 32'h9000_0010, 32'hFFFF_FFFF, 4'hF, 0, 1, irq_bits(0, 0));
      add_entry("core2 rd",      0, 32'h9800_0010, 0, 4'hF, 0, 1, irq_bits(0, 0));
      add_entry("core2 wr",      1, 32'h9800_0010, 32'h0003_1234, 4'hF, 0, 1, irq_bits(0, 0));
      add_entry("core0 idle rd", 0, 32'h9800_0000, 0, 4'hF, 0, 0, irq_bits(0, 0));
      add_entry("core1 idle rd", 0, 32'h9800_0008, 0, 4'hF, 0, 0, irq_bits(0, 0));
      add_entry("ram after err", 0, 32'h0000_0010, 0, 4'hF, 32'h11BB_EEDD, 0, irq_bits(0, 0));
      // SEND to core 1
      add_entry("core1 send",    1, 32'h9800_0008, 32'h0003_BEEF, 4'h0, 0, 0, irq_bits(1, 0));
      add_entry("core1 status",  0, 32'h9800_0008, 0, 4'hF, 32'h8003_BEEF, 0, irq_bits(1, 0));
      add_entry("core0 status",  0, 32'h9800_0000, 0, 4'hF, 0, 0, irq_bits(1, 0));
      add_entry("core1 ack rd",  0, 32'h9800_000C, 0, 4'hF, 0, 0, irq_bits(1, 0));
      // Busy mailbox, ACK and resend
      add_entry("core1 resend",  1, 32'h9800_0008, 32'h0005_1111, 4'hF, 0, 0, irq_bits(1, 0));
      add_entry("core1 kept",    0, 32'h9800_0008, 0, 4'hF, 32'h8003_BEEF, 0, irq_bits(1, 0));
      add_entry("core1 ack",     1, 32'h9800_000C, 32'h1234_5678, 4'hF, 0, 0, irq_bits(0, 0));
      add_entry("core1 cleared", 0, 32'h9800_0008, 0, 4'hF, 32'h0003_BEEF, 0, irq_bits(0, 0));
      add_entry("core1 send2",   1, 32'h9800_0008, 32'h0002_CAFE, 4'hF, 0, 0, irq_bits(1, 0));
      add_entry("core1 status2", 0, 32'h9800_0008, 0, 4'hF, 32'h8002_CAFE, 0, irq_bits(1, 0));
      add_entry("core0 send",    1, 32'h9800_0000, 32'h0001_0042, 4'hF, 0, 0, irq_bits(1, 1));
      add_entry("core1 ack2",    1, 32'h9800_000C, 0, 4'hF, 0, 0, irq_bits(0, 1));
      add_entry("core0 ack",     1, 32'h9800_0004, 0, 4'hF, 0, 0, irq_bits(0, 0));

      repeat (3) @(posedge wb_clk);
      @(negedge wb_clk);
      rst_n = 1'b1;
      check_value("reset ack", 64'd0, 64'(wb_ack));
      check_value("reset err", 64'd0, 64'(wb_err));
      check_value("reset data", 64'd0, 64'(wb_dat_r));
      check_value("reset irq", 64'd0, 64'(irq));

      for (int i = 0; i < t_name.size(); i++) begin
         bus_access(t_name[i], t_we[i], t_adr[i], t_dat[i], t_sel[i], rd, err);
         check_value({t_name[i], " err"}, 64'(t_err[i]), 64'(err));
         check_value({t_name[i], " data"}, 64'(t_exp[i]), 64'(rd));
         check_value({t_name[i], " irq"}, t_irq[i], 64'(irq));
      end

      ////////////////////////////////////////
      // Random RAM traffic
      ////////////////////////////////////////
      for (int n = 0; n < RAND_OPS; n++) begin
         rnd        = lcg_next();
         idx        = rnd[`RAM_ADR_BITS+7:8];
         alias_bits = rnd[31:32-$bits(alias_bits)];
         sel        = ref_valid[idx] ? rnd[3:0] : 4'hF;  // First write fills the word
         dat        = lcg_next();
         adr        = {{`RAM_REGION_WIDTH{1'b0}}, alias_bits, idx, 2'b00};
         bus_access($sformatf("rand wr %0d", n), 1'b1, adr, dat, sel, rd, err);
         check_value($sformatf("rand wr %0d err", n), 64'd0, 64'(err));
         for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
               ref_mem[idx][b*8 +: 8] = dat[b*8 +: 8];
            end
         end
         ref_valid[idx] = 1'b1;

         rnd    = lcg_next();
         idx_rd = rnd[`RAM_ADR_BITS+3:4];
         if (!ref_valid[idx_rd]) begin
            idx_rd = idx;
         end
         adr = {{`RAM_REGION_WIDTH{1'b0}}, rnd[31:32-$bits(alias_bits)], idx_rd, 2'b00};
         bus_access($sformatf("rand rd %0d", n), 1'b0, adr, '0, 4'hF, rd, err);
         check_value($sformatf("rand rd %0d err", n), 64'd0, 64'(err));
         check_value($sformatf("rand rd %0d data", n), 64'(ref_mem[idx_rd]), 64'(rd));
      end

      check_value("final irq", 64'd0, 64'(irq));
      $display("Testbench passed");
      $finish;
   end

endmodule
